/* source/uart_cfg.svh */
// UART loopback configuration: clock, baud rate, oversampling and FIFO sizing
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Core clock
`define CLK_FREQ_HZ 125000000

// Serial line rate, 8N1
`define UART_BAUD 115200

// Receiver samples per bit
`define UART_OVERSAMPLE 8

// Clock cycles per oversample tick, 135 at 125 MHz and 115200 baud
`define UART_PRESCALE (`CLK_FREQ_HZ / `UART_BAUD / `UART_OVERSAMPLE)

// Loopback FIFO entries, power of two
`define FIFO_DEPTH 16

// Occupancy at which cts tells the host to pause
`define FIFO_NEARLY_FULL 12

`endif

/* source/uart_pkg.sv */
// UART loopback types: character, counter and occupancy widths, FSM states
package uart_pkg;

// One serial character
typedef logic [7:0] uart_byte_t;

// Clock cycles within one oversample tick
typedef logic [15:0] prescale_cnt_t;

// FIFO occupancy, one bit wider than the address to hold the full count
typedef logic [4:0] fifo_level_t;

// Receiver FSM
typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} rx_state_t;

// Transmitter FSM
typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
} tx_state_t;

endpackage

/* source/uart_rx.sv */
// UART receiver: 8x oversampled 8N1 with start glitch rejection and stop bit check
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx import uart_pkg::*; (
    input  logic       clk_125mhz,
    input  logic       reset,
    input  logic       uart_rxd,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    output logic       frame_error,
    output logic       rx_busy
);

localparam int OS_W = $clog2(`UART_OVERSAMPLE);
// Cycles from the line edge to the first START cycle
localparam int SYNC_DELAY = 3;
localparam prescale_cnt_t PRESCALE_LAST = prescale_cnt_t'(`UART_PRESCALE - 1);
localparam prescale_cnt_t PRESCALE_FIRST = prescale_cnt_t'(`UART_PRESCALE - 1 - SYNC_DELAY);
localparam logic [OS_W-1:0] OS_LAST = OS_W'(`UART_OVERSAMPLE - 1);
localparam logic [OS_W-1:0] OS_MID = OS_W'(`UART_OVERSAMPLE / 2 - 1);

logic            rxd_meta;
logic            rxd_sync;
logic            break_hold;
rx_state_t       state;
prescale_cnt_t   prescale_cnt;
logic            os_tick;
logic [OS_W-1:0] os_cnt;
logic [2:0]      bit_cnt;
uart_byte_t      shift_reg;

// Two flop synchronizer, idles high
always_ff @(posedge clk_125mhz) begin
    if (reset) begin
        rxd_meta <= 1'b1;
        rxd_sync <= 1'b1;
    end else begin
        rxd_meta <= uart_rxd;
        rxd_sync <= rxd_meta;
    end
end

// Oversample tick generator
// The first tick is early by the synchronizer delay so samples land mid-bit
always_ff @(posedge clk_125mhz) begin
    if (reset || state == RX_IDLE) begin
        prescale_cnt <= PRESCALE_FIRST;
    end else if (prescale_cnt == '0) begin
        prescale_cnt <= PRESCALE_LAST;
    end else begin
        prescale_cnt <= prescale_cnt - 1'b1;
    end
end

assign os_tick = (state != RX_IDLE) && (prescale_cnt == '0);

always_ff @(posedge clk_125mhz) begin
    if (reset) begin
        state       <= RX_IDLE;
        os_cnt      <= '0;
        bit_cnt     <= '0;
        break_hold  <= 1'b0;
        rx_valid    <= 1'b0;
        frame_error <= 1'b0;
    end else begin
        rx_valid    <= 1'b0;
        frame_error <= 1'b0;
        if (rxd_sync) begin
            break_hold <= 1'b0;
        end

        case (state)
            RX_IDLE: begin
                os_cnt  <= '0;
                bit_cnt <= '0;
                // Wait for the line to go high again after a bad frame
                if (!rxd_sync && !break_hold) begin
                    state <= RX_START;
                end
            end
            RX_START: begin
                if (os_tick) begin
                    if (os_cnt == OS_MID) begin
                        os_cnt <= '0;
                        // High at mid start bit is a glitch, not a frame
                        state  <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
            end
            RX_DATA: begin
                if (os_tick) begin
                    if (os_cnt == OS_LAST) begin
                        os_cnt  <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
            end
            RX_STOP: begin
                if (os_tick) begin
                    if (os_cnt == OS_LAST) begin
                        os_cnt <= '0;
                        state  <= RX_IDLE;
                        if (rxd_sync) begin
                            rx_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                            break_hold  <= 1'b1;
                        end
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
            end
            default: state <= RX_IDLE;
        endcase
    end
end

// Data bits arrive LSB first
always_ff @(posedge clk_125mhz) begin
    if (state == RX_DATA && os_tick && os_cnt == OS_LAST) begin
        shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
end

assign rx_data = shift_reg;
assign rx_busy = (state != RX_IDLE);

// A frame ends either good or bad, never both
assert property (@(posedge clk_125mhz) disable iff (reset) !(rx_valid && frame_error))
    else $error("uart_rx: rx_valid and frame_error high in the same cycle");

endmodule

/* source/uart_tx.sv */
// UART transmitter: takes a byte from a valid/ready source and sends it 8N1
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tx import uart_pkg::*; (
    input  logic       clk_125mhz,
    input  logic       reset,
    input  uart_byte_t fifo_data,
    input  logic       fifo_valid,
    output logic       fifo_ready,
    input  logic       uart_rts,
    output logic       uart_txd,
    output logic       tx_busy
);

localparam int OS_W = $clog2(`UART_OVERSAMPLE);
localparam prescale_cnt_t PRESCALE_LAST = prescale_cnt_t'(`UART_PRESCALE - 1);
localparam logic [OS_W-1:0] OS_LAST = OS_W'(`UART_OVERSAMPLE - 1);

tx_state_t       state;
prescale_cnt_t   prescale_cnt;
logic [OS_W-1:0] os_cnt;
logic            bit_end;
logic            handshake;
logic [2:0]      bit_cnt;
uart_byte_t      shift_reg;

// Host holds rts high to pause, a frame in flight still completes
assign fifo_ready = (state == TX_IDLE) && !uart_rts;
assign handshake  = fifo_valid && fifo_ready;
assign tx_busy    = (state != TX_IDLE);

// Bit timer, prescale times oversample cycles per bit
always_ff @(posedge clk_125mhz) begin
    if (reset || state == TX_IDLE) begin
        prescale_cnt <= PRESCALE_LAST;
        os_cnt       <= '0;
    end else if (prescale_cnt == '0) begin
        prescale_cnt <= PRESCALE_LAST;
        os_cnt       <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
    end else begin
        prescale_cnt <= prescale_cnt - 1'b1;
    end
end

assign bit_end = (state != TX_IDLE) && (prescale_cnt == '0) && (os_cnt == OS_LAST);

always_ff @(posedge clk_125mhz) begin
    if (reset) begin
        state    <= TX_IDLE;
        bit_cnt  <= '0;
        uart_txd <= 1'b1;
    end else begin
        case (state)
            TX_IDLE: begin
                uart_txd <= 1'b1;
                bit_cnt  <= '0;
                if (handshake) begin
                    state    <= TX_START;
                    uart_txd <= 1'b0;
                end
            end
            TX_START: begin
                if (bit_end) begin
                    state    <= TX_DATA;
                    uart_txd <= shift_reg[0];
                end
            end
            TX_DATA: begin
                if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state    <= TX_STOP;
                        uart_txd <= 1'b1;
                    end else begin
                        uart_txd <= shift_reg[0];
                    end
                end
            end
            TX_STOP: begin
                if (bit_end) begin
                    state <= TX_IDLE;
                end
            end
            default: state <= TX_IDLE;
        endcase
    end
end

// LSB goes out first
always_ff @(posedge clk_125mhz) begin
    if (handshake) begin
        shift_reg <= fifo_data;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
        shift_reg <= {1'b0, shift_reg[7:1]};
    end
end

// Line rests high between frames
assert property (@(posedge clk_125mhz) disable iff (reset) (state == TX_IDLE) |-> uart_txd)
    else $error("uart_tx: uart_txd low while idle");

endmodule

/* source/uart_byte_fifo.sv */
// Byte FIFO between receiver and transmitter, drops on full and flags overrun
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_byte_fifo import uart_pkg::*; (
    input  logic       clk_125mhz,
    input  logic       reset,
    input  uart_byte_t wr_data,
    input  logic       wr_valid,
    output uart_byte_t rd_data,
    output logic       rd_valid,
    input  logic       rd_ready,
    output logic       nearly_full,
    output logic       overrun
);

localparam int ADDR_W = $clog2(`FIFO_DEPTH);
localparam fifo_level_t DEPTH_LVL = fifo_level_t'(`FIFO_DEPTH);
localparam fifo_level_t NEARLY_FULL_LVL = fifo_level_t'(`FIFO_NEARLY_FULL);

uart_byte_t        mem [`FIFO_DEPTH];
logic [ADDR_W-1:0] wr_ptr;
logic [ADDR_W-1:0] rd_ptr;
fifo_level_t       count;
fifo_level_t       count_next;
logic              push;
logic              pop;

assign rd_valid = (count != '0);
assign rd_data  = mem[rd_ptr];
assign pop      = rd_valid && rd_ready;
// Full still takes a write when a pop frees the slot in the same cycle
assign push     = wr_valid && ((count != DEPTH_LVL) || pop);

always_comb begin
    case ({push, pop})
        2'b10:   count_next = count + 1'b1;
        2'b01:   count_next = count - 1'b1;
        default: count_next = count;
    endcase
end

always_ff @(posedge clk_125mhz) begin
    if (push) begin
        mem[wr_ptr] <= wr_data;
    end
end

always_ff @(posedge clk_125mhz) begin
    if (reset) begin
        wr_ptr      <= '0;
        rd_ptr      <= '0;
        count       <= '0;
        nearly_full <= 1'b0;
        overrun     <= 1'b0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        count       <= count_next;
        nearly_full <= (count_next >= NEARLY_FULL_LVL);
        // Byte lost, receiver has no back-pressure
        overrun     <= wr_valid && !push;
    end
end

// Equal pointers mean empty unless the count says full
assert property (@(posedge clk_125mhz) disable iff (reset)
    pop |-> (rd_ptr != wr_ptr) || (count == DEPTH_LVL))
    else $error("uart_byte_fifo: pop from an empty FIFO");

assert property (@(posedge clk_125mhz) disable iff (reset) count <= DEPTH_LVL)
    else $error("uart_byte_fifo: occupancy above depth");

endmodule

/* source/fpga_core.sv */
// Board core: switches to LEDs and a UART receive, FIFO, transmit loopback
`timescale 1ns/100ps

module fpga_core import uart_pkg::*; (
    // 125 MHz clock, synchronous reset
    input  logic       clk_125mhz,
    input  logic       reset,

    // GPIO
    input  logic [7:0] sw,
    output logic [7:0] led,

    // UART, 115200 8N1 with hardware flow control
    input  logic       uart_rxd,
    output logic       uart_txd,
    input  logic       uart_rts,
    output logic       uart_cts,

    // Status pulses
    output logic       uart_frame_error,
    output logic       uart_overrun_error
);

uart_byte_t rx_data;
logic       rx_valid;
uart_byte_t fifo_data;
logic       fifo_valid;
logic       fifo_ready;
logic       fifo_nearly_full;

assign led = sw;

// High asks the host to stop sending
assign uart_cts = fifo_nearly_full;

// Receive path
uart_rx uart_rx_i (
    .clk_125mhz  (clk_125mhz),
    .reset       (reset),
    .uart_rxd    (uart_rxd),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .frame_error (uart_frame_error),
    .rx_busy     ()
);

// Buffer, absorbs bytes while the host holds rts
uart_byte_fifo uart_byte_fifo_i (
    .clk_125mhz  (clk_125mhz),
    .reset       (reset),
    .wr_data     (rx_data),
    .wr_valid    (rx_valid),
    .rd_data     (fifo_data),
    .rd_valid    (fifo_valid),
    .rd_ready    (fifo_ready),
    .nearly_full (fifo_nearly_full),
    .overrun     (uart_overrun_error)
);

// Echo path
uart_tx uart_tx_i (
    .clk_125mhz (clk_125mhz),
    .reset      (reset),
    .fifo_data  (fifo_data),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .uart_rts   (uart_rts),
    .uart_txd   (uart_txd),
    .tx_busy    ()
);

endmodule

/* sim/clock_gen.sv */
// Testbench clock and reset source, 100 ns period with reset held for 10 cycles
`timescale 1ns/100ps

module clock_gen (
    output logic clk_125mhz,
    output logic reset
);

localparam int RESET_CYCLES = 10;

initial begin
    clk_125mhz = 1'b0;
    forever #50 clk_125mhz = ~clk_125mhz;
end

// Released on a rising edge, as the core uses a synchronous reset
initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_125mhz);
    reset <= 1'b0;
end

endmodule

/* sim/fpga_core_tb.sv */
// Testbench for the board core: LED mirror, UART loopback echo, flow control and error pulses
`timescale 1ns/100ps
`include "uart_cfg.svh"

module fpga_core_tb import uart_pkg::*; ();

localparam int BIT_CYCLES = `UART_PRESCALE * `UART_OVERSAMPLE;
localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
// About 70 frames of 10800 cycles plus margin
localparam int TIMEOUT_CYCLES = 1000000;

logic       clk_125mhz;
logic       reset;
logic [7:0] sw;
logic [7:0] led;
logic       uart_rxd;
logic       uart_txd;
logic       uart_rts;
logic       uart_cts;
logic       uart_frame_error;
logic       uart_overrun_error;

logic [31:0] rng_state;
uart_byte_t  scoreboard [$];
logic        stim_started;
int          overrun_count;
int          frame_error_count;
int          echo_count;
// Last frame decoded from uart_txd
logic        echo_check;
logic        echo_known;
logic        echo_start;
logic        echo_stop;
uart_byte_t  echo_byte;
uart_byte_t  echo_ref;
// Expected state at a checkpoint
logic        status_check;
int          echoes_expected;
int          overruns_expected;
int          frame_errors_expected;
logic        cts_expected;

clock_gen clock_gen_i (.*);

fpga_core fpga_core_i (.*);

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic uart_byte_t random_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
endfunction

task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "fpga_core_tb stopped at the first error");
endtask

task automatic report_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    stop_with_failure();
endtask

task automatic report_problem(input string what);
    $display("ERROR at t=%0t: %s", $time, what);
    stop_with_failure();
endtask

// One 8N1 frame on uart_rxd, called on a falling edge
task automatic send_frame(input uart_byte_t data, input logic short_stop, input logic bad_stop);
    int i;
    if (!bad_stop) begin
        scoreboard.push_back(data);
    end
    uart_rxd = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk_125mhz);
    for (i = 0; i < 8; i++) begin
        uart_rxd = data[i];
        repeat (BIT_CYCLES) @(negedge clk_125mhz);
    end
    uart_rxd = !bad_stop;
    repeat (short_stop ? BIT_CYCLES / 2 : BIT_CYCLES) @(negedge clk_125mhz);
    uart_rxd = 1'b1;
endtask

task automatic wait_for_echoes(input int target);
    while (echo_count < target) begin
        @(negedge clk_125mhz);
    end
endtask

task automatic check_status(input int echoes, input int overruns, input int frame_errors,
                            input logic cts);
    echoes_expected       = echoes;
    overruns_expected     = overruns;
    frame_errors_expected = frame_errors;
    cts_expected          = cts;
    status_check          = 1'b1;
    @(negedge clk_125mhz);
    status_check = 1'b0;
endtask

// LEDs follow the switches on every cycle
assert property (@(posedge clk_125mhz) led == sw)
    else report_mismatch("led", sw, $sampled(led));

// Quiet outputs between reset and the first byte
assert property (@(posedge clk_125mhz) disable iff (reset) !stim_started |-> uart_txd)
    else report_mismatch("uart_txd", 1, $sampled(uart_txd));
assert property (@(posedge clk_125mhz) disable iff (reset) !stim_started |-> !uart_cts)
    else report_mismatch("uart_cts", 0, $sampled(uart_cts));
assert property (@(posedge clk_125mhz) disable iff (reset) !stim_started |-> !uart_frame_error)
    else report_mismatch("uart_frame_error", 0, $sampled(uart_frame_error));
assert property (@(posedge clk_125mhz) disable iff (reset)
    !stim_started |-> !uart_overrun_error)
    else report_mismatch("uart_overrun_error", 0, $sampled(uart_overrun_error));

// Line stays idle while the host holds rts, the FIFO is empty when rts rises
assert property (@(posedge clk_125mhz) disable iff (reset) uart_rts |-> uart_txd)
    else report_problem("start bit on uart_txd while uart_rts is high");

assert property (@(posedge clk_125mhz) echo_check |-> echo_known)
    else report_problem("byte echoed on uart_txd with no byte left to expect");
assert property (@(posedge clk_125mhz) echo_check |-> !echo_start)
    else report_mismatch("uart_txd start bit", 0, echo_start);
assert property (@(posedge clk_125mhz) echo_check |-> echo_stop)
    else report_mismatch("uart_txd stop bit", 1, echo_stop);
assert property (@(posedge clk_125mhz) (echo_check && echo_known) |-> echo_byte == echo_ref)
    else report_mismatch("uart_txd data", echo_ref, echo_byte);

assert property (@(posedge clk_125mhz) status_check |-> echo_count == echoes_expected)
    else report_mismatch("uart_txd echo count", echoes_expected, echo_count);
assert property (@(posedge clk_125mhz) status_check |-> overrun_count == overruns_expected)
    else report_mismatch("uart_overrun_error pulses", overruns_expected, overrun_count);
assert property (@(posedge clk_125mhz)
    status_check |-> frame_error_count == frame_errors_expected)
    else report_mismatch("uart_frame_error pulses", frame_errors_expected, frame_error_count);
assert property (@(posedge clk_125mhz) status_check |-> uart_cts == cts_expected)
    else report_mismatch("uart_cts", cts_expected, $sampled(uart_cts));

// Each pulse is one cycle wide, so one falling edge sees it
always @(negedge clk_125mhz) begin
    if (reset) begin
        overrun_count     <= 0;
        frame_error_count <= 0;
    end else begin
        if (uart_overrun_error) begin
            overrun_count <= overrun_count + 1;
        end
        if (uart_frame_error) begin
            frame_error_count <= frame_error_count + 1;
        end
    end
end

// Serial monitor, samples uart_txd at mid-bit on falling edges
initial begin : txd_monitor
    uart_byte_t bits;
    int         dropped;
    int         i;
    echo_check = 1'b0;
    echo_count = 0;
    dropped    = 0;
    wait (reset == 1'b0);
    forever begin
        @(negedge clk_125mhz);
        echo_check = 1'b0;
        if (uart_txd === 1'b0) begin
            repeat (BIT_CYCLES / 2) @(negedge clk_125mhz);
            echo_start = uart_txd;
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk_125mhz);
                bits[i] = uart_txd;
            end
            repeat (BIT_CYCLES) @(negedge clk_125mhz);
            echo_stop = uart_txd;
            // Bytes lost to an overrun never come back
            while (scoreboard.size() > 1 && scoreboard[0] != bits && overrun_count > dropped) begin
                void'(scoreboard.pop_front());
                dropped++;
            end
            echo_known = (scoreboard.size() > 0);
            if (echo_known) begin
                echo_ref = scoreboard.pop_front();
            end
            echo_byte  = bits;
            echo_count = echo_count + 1;
            echo_check = 1'b1;
        end
    end
end

initial begin : watchdog
    int unsigned cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge clk_125mhz);
        cycle_count++;
    end
    report_problem("timeout, the tests did not finish within the cycle limit");
end

initial begin : stimulus
    int k;
    int echoes;
    sw           = '0;
    uart_rxd     = 1'b1;
    uart_rts     = 1'b0;
    stim_started = 1'b0;
    status_check = 1'b0;
    rng_state    = 32'd62905;
    echoes       = 0;
    wait (reset == 1'b0);
    @(negedge clk_125mhz);

    // Switch patterns while the UART is idle
    repeat (8) begin
        sw = random_byte();
        repeat (10) @(negedge clk_125mhz);
    end
    check_status(0, 0, 0, 1'b0);
    stim_started = 1'b1;

    // Single bytes with idle gaps
    repeat (3) begin
        send_frame(random_byte(), 1'b0, 1'b0);
        echoes++;
        wait_for_echoes(echoes);
        repeat (2 * BIT_CYCLES) @(negedge clk_125mhz);
    end
    check_status(echoes, 0, 0, 1'b0);

    // Back to back with half stop bits
    repeat (10) begin
        send_frame(random_byte(), 1'b1, 1'b0);
    end
    echoes += 10;
    wait_for_echoes(echoes);
    check_status(echoes, 0, 0, 1'b0);

    // Host pauses the echo, FIFO fills and then overflows
    uart_rts = 1'b1;
    for (k = 1; k <= 20; k++) begin
        send_frame(random_byte(), 1'b0, 1'b0);
        check_status(echoes, (k > 16) ? k - 16 : 0, 0, k >= 12);
    end
    uart_rts = 1'b0;
    echoes += 16;
    wait_for_echoes(echoes);
    check_status(echoes, 4, 0, 1'b0);

    // Low stop bit, then a good byte
    send_frame(random_byte(), 1'b0, 1'b1);
    repeat (2 * FRAME_CYCLES) @(negedge clk_125mhz);
    check_status(echoes, 4, 1, 1'b0);
    send_frame(random_byte(), 1'b0, 1'b0);
    echoes++;
    wait_for_echoes(echoes);
    check_status(echoes, 4, 1, 1'b0);

    repeat (BIT_CYCLES) @(negedge clk_125mhz);
    $display("TEST RESULT: PASS");
    $finish;
end

endmodule

/* filelist.f */
+incdir+source
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_byte_fifo.sv
source/fpga_core.sv
sim/clock_gen.sv
sim/fpga_core_tb.sv
